// File: source/aib_sm_pkg.sv
// AIB master sequencer definitions
package aib_sm_pkg;

    // ====================
    // Synchronizer setup
    // ====================
    localparam int SYNC_STAGES_DEF = 2;
    localparam int SYNC_W          = 11;

    // Bit positions in the synchronized vector
    localparam int SYNC_IDX_CFG_DONE       = 0;
    localparam int SYNC_IDX_SL_OSC_EN      = 1;
    localparam int SYNC_IDX_MS_RX_REQ      = 2;
    localparam int SYNC_IDX_SL_TX_REQ      = 3;
    localparam int SYNC_IDX_SL_TX_DCC_DONE = 4;
    localparam int SYNC_IDX_MS_RX_LOCK     = 5;
    localparam int SYNC_IDX_MS_TX_REQ      = 6;
    localparam int SYNC_IDX_SL_RX_REQ      = 7;
    localparam int SYNC_IDX_MS_TX_DCC_DONE = 8;
    localparam int SYNC_IDX_SL_RX_LOCK     = 9;
    localparam int SYNC_IDX_SL_RX_XFER_EN  = 10;

    // ====================
    // State encodings
    // ====================
    typedef enum logic [1:0] {
        OSC_WAIT_RDY = 2'd0,
        OSC_XFER_EN  = 2'd1,
        OSC_ALIVE    = 2'd2
    } osc_state_t;

    // Remote TX to local RX, order matters for output decode
    typedef enum logic [2:0] {
        RX_WAIT_REQ      = 3'd0,
        RX_WAIT_REMT_DCC = 3'd1,
        RX_LOCK_REQ      = 3'd2,
        RX_LOCKED        = 3'd3,
        RX_XFER_EN       = 3'd4
    } rx_cal_state_t;

    typedef enum logic [2:0] {
        TX_WAIT_REQ       = 3'd0,
        TX_DCC_REQ        = 3'd1,
        TX_WAIT_REMT_LOCK = 3'd2,
        TX_WAIT_REMT_XFER = 3'd3,
        TX_XFER_EN        = 3'd4
    } tx_cal_state_t;

endpackage

// File: source/input_sync_bank.sv
// Level input synchronizer bank
`timescale 1ns/1ns

module input_sync_bank #(
    parameter int SYNC_STAGES = aib_sm_pkg::SYNC_STAGES_DEF,
    parameter int SYNC_W      = aib_sm_pkg::SYNC_W
) (
    input  logic              osc_clk,
    input  logic              ms_reset_n_sync,
    input  logic [SYNC_W-1:0] i_async_vec,
    output logic [SYNC_W-1:0] o_sync_vec
);

    logic [SYNC_W-1:0] stage_q [SYNC_STAGES];  // Stage 0 samples the pins

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= i_async_vec;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];  // Shift toward output
            end
        end
    end

    assign o_sync_vec = stage_q[SYNC_STAGES-1];

endmodule

// File: source/osc_sync_ctrl.sv
// Oscillator sync control
`timescale 1ns/1ns

module osc_sync_ctrl (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_cfg_done,
    input  logic i_sl_osc_en,
    output logic o_osc_transfer_en,
    output logic o_osc_transfer_alive,
    output logic o_link_alive
);

    import aib_sm_pkg::*;

    osc_state_t state_q;
    osc_state_t state_nxt;
    logic       xfer_en_q;
    logic       alive_q;

    // ====================
    // State machine
    // ====================
    always_comb begin
        state_nxt = state_q;
        if (!i_cfg_done) begin
            state_nxt = OSC_WAIT_RDY;  // Config lost
        end else begin
            case (state_q)
                OSC_WAIT_RDY: state_nxt = OSC_XFER_EN;
                OSC_XFER_EN: begin
                    if (i_sl_osc_en) begin
                        state_nxt = OSC_ALIVE;  // Remote echoed enable
                    end
                end
                OSC_ALIVE:    state_nxt = OSC_ALIVE;
                default:      state_nxt = OSC_WAIT_RDY;
            endcase
        end
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            state_q   <= OSC_WAIT_RDY;
            xfer_en_q <= 1'b0;
            alive_q   <= 1'b0;
        end else begin
            state_q   <= state_nxt;
            xfer_en_q <= (state_q == OSC_XFER_EN) || (state_q == OSC_ALIVE);
            alive_q   <= (state_q == OSC_ALIVE);
        end
    end

    assign o_osc_transfer_en    = xfer_en_q;
    assign o_osc_transfer_alive = alive_q;
    assign o_link_alive         = alive_q;  // Gates both sequencers

endmodule

// File: source/rx_cal_seq.sv
// Remote TX to local RX calibration
`timescale 1ns/1ns

module rx_cal_seq (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_link_alive,
    input  logic i_ms_rx_req,
    input  logic i_sl_tx_req,
    input  logic i_sl_tx_dcc_done,
    input  logic i_ms_rx_lock,
    output logic o_rx_async_rst,
    output logic o_rx_dll_lock_req,
    output logic o_rx_dll_lock,
    output logic o_rx_transfer_en
);

    import aib_sm_pkg::*;

    rx_cal_state_t state_q;
    rx_cal_state_t state_nxt;
    logic          req_ok;

    // Both sides want calibration and the link is up
    assign req_ok = i_link_alive & i_ms_rx_req & i_sl_tx_req;

    // ====================
    // State machine
    // ====================
    always_comb begin
        state_nxt = state_q;
        if (!req_ok) begin
            state_nxt = RX_WAIT_REQ;  // Abort from anywhere
        end else begin
            case (state_q)
                RX_WAIT_REQ:      state_nxt = RX_WAIT_REMT_DCC;
                RX_WAIT_REMT_DCC: begin
                    if (i_sl_tx_dcc_done) begin
                        state_nxt = RX_LOCK_REQ;
                    end
                end
                RX_LOCK_REQ: begin
                    if (i_ms_rx_lock) begin
                        state_nxt = RX_LOCKED;
                    end
                end
                RX_LOCKED:        state_nxt = RX_XFER_EN;  // Single cycle
                RX_XFER_EN:       state_nxt = RX_XFER_EN;
                default:          state_nxt = RX_WAIT_REQ;
            endcase
        end
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            state_q <= RX_WAIT_REQ;
        end else begin
            state_q <= state_nxt;
        end
    end

    // ====================
    // Output decode
    // ====================
    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            o_rx_async_rst    <= 1'b0;
            o_rx_dll_lock_req <= 1'b0;
            o_rx_dll_lock     <= 1'b0;
            o_rx_transfer_en  <= 1'b0;
        end else begin
            o_rx_async_rst    <= (state_q != RX_WAIT_REQ);
            o_rx_dll_lock_req <= (state_q >= RX_LOCK_REQ);
            o_rx_dll_lock     <= (state_q >= RX_LOCKED);
            o_rx_transfer_en  <= (state_q == RX_XFER_EN);
        end
    end

endmodule

// File: source/tx_cal_seq.sv
// Local TX to remote RX calibration
`timescale 1ns/1ns

module tx_cal_seq (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_link_alive,
    input  logic i_ms_tx_req,
    input  logic i_sl_rx_req,
    input  logic i_ms_tx_dcc_done,
    input  logic i_sl_rx_lock,
    input  logic i_sl_rx_xfer_en,
    output logic o_tx_async_rst,
    output logic o_tx_dcc_cal_req,
    output logic o_tx_dcc_cal_done,
    output logic o_tx_transfer_en
);

    import aib_sm_pkg::*;

    tx_cal_state_t state_q;
    tx_cal_state_t state_nxt;
    logic          req_ok;

    assign req_ok = i_link_alive & i_ms_tx_req & i_sl_rx_req;

    // ====================
    // State machine
    // ====================
    always_comb begin
        state_nxt = state_q;
        if (!req_ok) begin
            state_nxt = TX_WAIT_REQ;  // Abort from anywhere
        end else begin
            case (state_q)
                TX_WAIT_REQ:       state_nxt = TX_DCC_REQ;
                TX_DCC_REQ: begin
                    if (i_ms_tx_dcc_done) begin
                        state_nxt = TX_WAIT_REMT_LOCK;  // Local DCC finished
                    end
                end
                TX_WAIT_REMT_LOCK: begin
                    if (i_sl_rx_lock) begin
                        state_nxt = TX_WAIT_REMT_XFER;
                    end
                end
                TX_WAIT_REMT_XFER: begin
                    if (i_sl_rx_xfer_en) begin
                        state_nxt = TX_XFER_EN;
                    end
                end
                TX_XFER_EN:        state_nxt = TX_XFER_EN;
                default:           state_nxt = TX_WAIT_REQ;
            endcase
        end
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            state_q <= TX_WAIT_REQ;
        end else begin
            state_q <= state_nxt;
        end
    end

    // ====================
    // Output decode
    // ====================
    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            o_tx_async_rst    <= 1'b0;
            o_tx_dcc_cal_req  <= 1'b0;
            o_tx_dcc_cal_done <= 1'b0;
            o_tx_transfer_en  <= 1'b0;
        end else begin
            o_tx_async_rst    <= (state_q != TX_WAIT_REQ);
            o_tx_dcc_cal_req  <= (state_q >= TX_DCC_REQ);
            o_tx_dcc_cal_done <= (state_q >= TX_WAIT_REMT_LOCK);
            o_tx_transfer_en  <= (state_q == TX_XFER_EN);
        end
    end

endmodule

// File: source/aib_master_sm.sv
// AIB master bring-up sequencer
`timescale 1ns/1ns

module aib_master_sm #(
    parameter int SYNC_STAGES = aib_sm_pkg::SYNC_STAGES_DEF
) (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_ms_config_done,
    input  logic i_sl_osc_transfer_en,
    input  logic i_ms_rx_dcc_dll_lock_req,
    input  logic i_sl_tx_dcc_dll_lock_req,
    input  logic i_sl_tx_dcc_cal_done,
    input  logic i_ms_rx_dll_lock,
    input  logic i_ms_tx_dcc_dll_lock_req,
    input  logic i_sl_rx_dcc_dll_lock_req,
    input  logic i_ms_tx_dcc_cal_done,
    input  logic i_sl_rx_dll_lock,
    input  logic i_sl_rx_transfer_en,
    output logic o_ms_osc_transfer_en,
    output logic o_ms_osc_transfer_alive,
    output logic o_ms_rx_async_rst,
    output logic o_ms_rx_dll_lock_req,
    output logic o_ms_rx_dll_lock,
    output logic o_ms_rx_transfer_en,
    output logic o_ms_tx_async_rst,
    output logic o_ms_tx_dcc_cal_req,
    output logic o_ms_tx_dcc_cal_done,
    output logic o_ms_tx_transfer_en
);

    import aib_sm_pkg::*;

    logic [SYNC_W-1:0] async_vec;
    logic [SYNC_W-1:0] sync_vec;
    logic              link_alive;

    // ====================
    // Input crossing
    // ====================
    assign async_vec[SYNC_IDX_CFG_DONE]       = i_ms_config_done;
    assign async_vec[SYNC_IDX_SL_OSC_EN]      = i_sl_osc_transfer_en;
    assign async_vec[SYNC_IDX_MS_RX_REQ]      = i_ms_rx_dcc_dll_lock_req;
    assign async_vec[SYNC_IDX_SL_TX_REQ]      = i_sl_tx_dcc_dll_lock_req;
    assign async_vec[SYNC_IDX_SL_TX_DCC_DONE] = i_sl_tx_dcc_cal_done;
    assign async_vec[SYNC_IDX_MS_RX_LOCK]     = i_ms_rx_dll_lock;
    assign async_vec[SYNC_IDX_MS_TX_REQ]      = i_ms_tx_dcc_dll_lock_req;
    assign async_vec[SYNC_IDX_SL_RX_REQ]      = i_sl_rx_dcc_dll_lock_req;
    assign async_vec[SYNC_IDX_MS_TX_DCC_DONE] = i_ms_tx_dcc_cal_done;
    assign async_vec[SYNC_IDX_SL_RX_LOCK]     = i_sl_rx_dll_lock;
    assign async_vec[SYNC_IDX_SL_RX_XFER_EN]  = i_sl_rx_transfer_en;

    input_sync_bank #(
        .SYNC_STAGES (SYNC_STAGES),
        .SYNC_W      (SYNC_W)
    ) u_sync (
        .osc_clk         (osc_clk),
        .ms_reset_n_sync (ms_reset_n_sync),
        .i_async_vec     (async_vec),
        .o_sync_vec      (sync_vec)
    );

    // ====================
    // Sequencers
    // ====================
    osc_sync_ctrl u_osc (
        .osc_clk              (osc_clk),
        .ms_reset_n_sync      (ms_reset_n_sync),
        .i_cfg_done           (sync_vec[SYNC_IDX_CFG_DONE]),
        .i_sl_osc_en          (sync_vec[SYNC_IDX_SL_OSC_EN]),
        .o_osc_transfer_en    (o_ms_osc_transfer_en),
        .o_osc_transfer_alive (o_ms_osc_transfer_alive),
        .o_link_alive         (link_alive)
    );

    rx_cal_seq u_rx (
        .osc_clk           (osc_clk),
        .ms_reset_n_sync   (ms_reset_n_sync),
        .i_link_alive      (link_alive),
        .i_ms_rx_req       (sync_vec[SYNC_IDX_MS_RX_REQ]),
        .i_sl_tx_req       (sync_vec[SYNC_IDX_SL_TX_REQ]),
        .i_sl_tx_dcc_done  (sync_vec[SYNC_IDX_SL_TX_DCC_DONE]),
        .i_ms_rx_lock      (sync_vec[SYNC_IDX_MS_RX_LOCK]),
        .o_rx_async_rst    (o_ms_rx_async_rst),
        .o_rx_dll_lock_req (o_ms_rx_dll_lock_req),
        .o_rx_dll_lock     (o_ms_rx_dll_lock),
        .o_rx_transfer_en  (o_ms_rx_transfer_en)
    );

    tx_cal_seq u_tx (
        .osc_clk           (osc_clk),
        .ms_reset_n_sync   (ms_reset_n_sync),
        .i_link_alive      (link_alive),
        .i_ms_tx_req       (sync_vec[SYNC_IDX_MS_TX_REQ]),
        .i_sl_rx_req       (sync_vec[SYNC_IDX_SL_RX_REQ]),
        .i_ms_tx_dcc_done  (sync_vec[SYNC_IDX_MS_TX_DCC_DONE]),
        .i_sl_rx_lock      (sync_vec[SYNC_IDX_SL_RX_LOCK]),
        .i_sl_rx_xfer_en   (sync_vec[SYNC_IDX_SL_RX_XFER_EN]),
        .o_tx_async_rst    (o_ms_tx_async_rst),
        .o_tx_dcc_cal_req  (o_ms_tx_dcc_cal_req),
        .o_tx_dcc_cal_done (o_ms_tx_dcc_cal_done),
        .o_tx_transfer_en  (o_ms_tx_transfer_en)
    );

endmodule

// File: dv/aib_master_sm_sva.sv
// Sequencer output assertions
`timescale 1ns/1ns

module aib_master_sm_sva (
    input logic osc_clk,
    input logic ms_reset_n_sync,
    input logic i_osc_alive,
    input logic i_rx_async_rst,
    input logic i_rx_dll_lock_req,
    input logic i_rx_dll_lock,
    input logic i_rx_transfer_en,
    input logic i_tx_async_rst,
    input logic i_tx_dcc_cal_req,
    input logic i_tx_dcc_cal_done,
    input logic i_tx_transfer_en
);

    logic seq_any;

    assign seq_any = i_rx_async_rst | i_rx_dll_lock_req | i_rx_dll_lock | i_rx_transfer_en |
                     i_tx_async_rst | i_tx_dcc_cal_req | i_tx_dcc_cal_done | i_tx_transfer_en;

    rx_xfer_after_lock: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        i_rx_transfer_en |-> i_rx_dll_lock)
        else $error("RX transfer enable is high without the DLL lock");

    tx_xfer_after_dcc: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        i_tx_transfer_en |-> i_tx_dcc_cal_done)
        else $error("TX transfer enable is high without DCC calibration done");

    // Alive reaches the sequencer outputs through state and output registers
    seq_needs_alive: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        seq_any |-> $past(i_osc_alive, 2))
        else $error("Sequencer output is high while the link is not alive");

endmodule

bind aib_master_sm aib_master_sm_sva u_sva (
    .osc_clk           (osc_clk),
    .ms_reset_n_sync   (ms_reset_n_sync),
    .i_osc_alive       (o_ms_osc_transfer_alive),
    .i_rx_async_rst    (o_ms_rx_async_rst),
    .i_rx_dll_lock_req (o_ms_rx_dll_lock_req),
    .i_rx_dll_lock     (o_ms_rx_dll_lock),
    .i_rx_transfer_en  (o_ms_rx_transfer_en),
    .i_tx_async_rst    (o_ms_tx_async_rst),
    .i_tx_dcc_cal_req  (o_ms_tx_dcc_cal_req),
    .i_tx_dcc_cal_done (o_ms_tx_dcc_cal_done),
    .i_tx_transfer_en  (o_ms_tx_transfer_en)
);

// File: dv/aib_master_sm_tb.sv
// AIB master sequencer testbench
`timescale 1ns/1ns

module aib_master_sm_tb;

    localparam int SYNC_STAGES    = 2;
    localparam int SETTLE         = SYNC_STAGES + 3;
    localparam int SETTLE_LINK    = SETTLE + 2;  // Extra hop through link_alive
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_ROWS       = 15;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * (SETTLE_LINK + 1) + 20;

    logic osc_clk;
    logic ms_reset_n_sync;
    logic i_ms_config_done;
    logic i_sl_osc_transfer_en;
    logic i_ms_rx_dcc_dll_lock_req;
    logic i_sl_tx_dcc_dll_lock_req;
    logic i_sl_tx_dcc_cal_done;
    logic i_ms_rx_dll_lock;
    logic i_ms_tx_dcc_dll_lock_req;
    logic i_sl_rx_dcc_dll_lock_req;
    logic i_ms_tx_dcc_cal_done;
    logic i_sl_rx_dll_lock;
    logic i_sl_rx_transfer_en;
    logic o_ms_osc_transfer_en;
    logic o_ms_osc_transfer_alive;
    logic o_ms_rx_async_rst;
    logic o_ms_rx_dll_lock_req;
    logic o_ms_rx_dll_lock;
    logic o_ms_rx_transfer_en;
    logic o_ms_tx_async_rst;
    logic o_ms_tx_dcc_cal_req;
    logic o_ms_tx_dcc_cal_done;
    logic o_ms_tx_transfer_en;

    logic [10:0] row_in   [NUM_ROWS];
    logic [9:0]  row_exp  [NUM_ROWS];
    int          row_wait [NUM_ROWS];
    int          row_cnt     = 0;
    int          error_count = 0;
    int          cycle_cnt   = 0;

    aib_master_sm #(
        .SYNC_STAGES (SYNC_STAGES)
    ) dut0 (
        .osc_clk                  (osc_clk),
        .ms_reset_n_sync          (ms_reset_n_sync),
        .i_ms_config_done         (i_ms_config_done),
        .i_sl_osc_transfer_en     (i_sl_osc_transfer_en),
        .i_ms_rx_dcc_dll_lock_req (i_ms_rx_dcc_dll_lock_req),
        .i_sl_tx_dcc_dll_lock_req (i_sl_tx_dcc_dll_lock_req),
        .i_sl_tx_dcc_cal_done     (i_sl_tx_dcc_cal_done),
        .i_ms_rx_dll_lock         (i_ms_rx_dll_lock),
        .i_ms_tx_dcc_dll_lock_req (i_ms_tx_dcc_dll_lock_req),
        .i_sl_rx_dcc_dll_lock_req (i_sl_rx_dcc_dll_lock_req),
        .i_ms_tx_dcc_cal_done     (i_ms_tx_dcc_cal_done),
        .i_sl_rx_dll_lock         (i_sl_rx_dll_lock),
        .i_sl_rx_transfer_en      (i_sl_rx_transfer_en),
        .o_ms_osc_transfer_en     (o_ms_osc_transfer_en),
        .o_ms_osc_transfer_alive  (o_ms_osc_transfer_alive),
        .o_ms_rx_async_rst        (o_ms_rx_async_rst),
        .o_ms_rx_dll_lock_req     (o_ms_rx_dll_lock_req),
        .o_ms_rx_dll_lock         (o_ms_rx_dll_lock),
        .o_ms_rx_transfer_en      (o_ms_rx_transfer_en),
        .o_ms_tx_async_rst        (o_ms_tx_async_rst),
        .o_ms_tx_dcc_cal_req      (o_ms_tx_dcc_cal_req),
        .o_ms_tx_dcc_cal_done     (o_ms_tx_dcc_cal_done),
        .o_ms_tx_transfer_en      (o_ms_tx_transfer_en)
    );

    initial osc_clk = 1'b0;
    always #50 osc_clk = ~osc_clk;

    always @(posedge osc_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ====================
    // Table helpers
    // ====================
    task automatic add_row(input logic [10:0] in_bits, input logic [9:0] exp_bits,
                           input int wait_cycles);
        row_in[row_cnt]   = in_bits;
        row_exp[row_cnt]  = exp_bits;
        row_wait[row_cnt] = wait_cycles;
        row_cnt++;
    endtask

    task automatic compare_value(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, expected,
                     actual);
        end
    endtask

    task automatic drive_inputs(input logic [10:0] bits);
        i_ms_config_done         <= bits[10];
        i_sl_osc_transfer_en     <= bits[9];
        i_ms_rx_dcc_dll_lock_req <= bits[8];
        i_sl_tx_dcc_dll_lock_req <= bits[7];
        i_sl_tx_dcc_cal_done     <= bits[6];
        i_ms_rx_dll_lock         <= bits[5];
        i_ms_tx_dcc_dll_lock_req <= bits[4];
        i_sl_rx_dcc_dll_lock_req <= bits[3];
        i_ms_tx_dcc_cal_done     <= bits[2];
        i_sl_rx_dll_lock         <= bits[1];
        i_sl_rx_transfer_en      <= bits[0];
    endtask

    task automatic check_outputs(input logic [9:0] exp_bits);
        compare_value("o_ms_osc_transfer_en", exp_bits[9], o_ms_osc_transfer_en);
        compare_value("o_ms_osc_transfer_alive", exp_bits[8], o_ms_osc_transfer_alive);
        compare_value("o_ms_rx_async_rst", exp_bits[7], o_ms_rx_async_rst);
        compare_value("o_ms_rx_dll_lock_req", exp_bits[6], o_ms_rx_dll_lock_req);
        compare_value("o_ms_rx_dll_lock", exp_bits[5], o_ms_rx_dll_lock);
        compare_value("o_ms_rx_transfer_en", exp_bits[4], o_ms_rx_transfer_en);
        compare_value("o_ms_tx_async_rst", exp_bits[3], o_ms_tx_async_rst);
        compare_value("o_ms_tx_dcc_cal_req", exp_bits[2], o_ms_tx_dcc_cal_req);
        compare_value("o_ms_tx_dcc_cal_done", exp_bits[1], o_ms_tx_dcc_cal_done);
        compare_value("o_ms_tx_transfer_en", exp_bits[0], o_ms_tx_transfer_en);
    endtask

    // Inputs: cfg,osc_en | rx_req,tx_req,tx_dcc_done,rx_lock | tx_req,rx_req,dcc,lock,xfer
    // Outputs: xfer_en,alive | rst,lock_req,lock,xfer_en | rst,dcc_req,dcc_done,xfer_en
    task automatic load_table();
        add_row(11'b00_0000_00000, 10'b00_0000_0000, SETTLE);       // Idle after reset
        add_row(11'b01_1111_11111, 10'b00_0000_0000, SETTLE);       // No config, all else high
        add_row(11'b00_0000_00000, 10'b00_0000_0000, SETTLE);
        add_row(11'b10_0000_00000, 10'b10_0000_0000, SETTLE);       // Config done
        add_row(11'b11_0000_00000, 10'b11_0000_0000, SETTLE);       // Remote osc echo
        add_row(11'b11_1100_00000, 10'b11_1000_0000, SETTLE);       // RX requests
        add_row(11'b11_1110_00000, 10'b11_1100_0000, SETTLE);       // Remote DCC done
        add_row(11'b11_1111_00000, 10'b11_1111_0000, SETTLE);       // Local DLL lock
        add_row(11'b11_1111_11000, 10'b11_1111_1100, SETTLE);       // TX requests
        add_row(11'b11_1111_11100, 10'b11_1111_1110, SETTLE);       // Local DCC done
        add_row(11'b11_1111_11110, 10'b11_1111_1110, SETTLE);       // Remote lock only
        add_row(11'b11_1111_11111, 10'b11_1111_1111, SETTLE);       // Remote RX enable
        add_row(11'b11_0111_11111, 10'b11_0000_1111, SETTLE);       // Drop local RX request
        add_row(11'b01_0111_11111, 10'b00_0000_0000, SETTLE_LINK);  // Drop config done
        add_row(11'b01_1111_11111, 10'b00_0000_0000, SETTLE);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        ms_reset_n_sync = 1'b0;
        drive_inputs(11'b0);
        load_table();
        repeat (RESET_CYCLES) @(posedge osc_clk);
        ms_reset_n_sync <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge osc_clk);
            drive_inputs(row_in[r]);
            repeat (row_wait[r]) @(posedge osc_clk);
            @(negedge osc_clk);  // Outputs stable mid-cycle
            check_outputs(row_exp[r]);
        end
        $display("Finished %0d rows with %0d errors", NUM_ROWS, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/aib_sm_pkg.sv
source/input_sync_bank.sv
source/osc_sync_ctrl.sv
source/rx_cal_seq.sv
source/tx_cal_seq.sv
source/aib_master_sm.sv
dv/aib_master_sm_sva.sv
dv/aib_master_sm_tb.sv

// File: Makefile
TOP := aib_master_sm_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir
